// ==== ao_peripheral.sv ====
/* Always-on registers for GPIO, pre-load status and simulation exit.
   NUM_GPIO must not exceed the bus width. Exit stays valid until reset. */
`timescale 1ns/1ps

module ao_peripheral #(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mcu_pkg::obi_req_t         req_i,
  output logic [mcu_pkg::XLEN-1:0]  rdata_o,
  input  logic                      pre_load_finished_i,
  input  logic [NUM_GPIO-1:0]       gpio_i,
  output logic [NUM_GPIO-1:0]       gpio_o,
  output logic [NUM_GPIO-1:0]       gpio_oe_o,
  output logic                      exit_valid_o,
  output logic [mcu_pkg::XLEN-1:0]  exit_value_o
);

  logic [NUM_GPIO-1:0]      gpio_out_q;
  logic [NUM_GPIO-1:0]      gpio_oe_q;
  logic [NUM_GPIO-1:0]      gpio_meta_q;
  logic [NUM_GPIO-1:0]      gpio_sync_q;
  logic                     exit_valid_q;
  logic [mcu_pkg::XLEN-1:0] exit_value_q;
  logic [mcu_pkg::XLEN-1:0] rdata_d;
  logic [mcu_pkg::XLEN-1:0] rdata_q;
  logic                     wr_en;

  assign wr_en = req_i.req && req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      gpio_oe_q    <= '0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (req_i.addr)
        mcu_pkg::GPIO_OUT_OFFSET: gpio_out_q <= req_i.wdata[NUM_GPIO-1:0];
        mcu_pkg::GPIO_OE_OFFSET:  gpio_oe_q  <= req_i.wdata[NUM_GPIO-1:0];
        mcu_pkg::EXIT_OFFSET: begin
          exit_valid_q <= 1'b1;
          exit_value_q <= req_i.wdata;
        end
        default: ;
      endcase
    end
  end

  // two-stage input synchronizer
  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
  end

  always_comb begin
    case (req_i.addr)
      mcu_pkg::GPIO_OUT_OFFSET: rdata_d = mcu_pkg::XLEN'(gpio_out_q);
      mcu_pkg::GPIO_OE_OFFSET:  rdata_d = mcu_pkg::XLEN'(gpio_oe_q);
      mcu_pkg::GPIO_IN_OFFSET:  rdata_d = mcu_pkg::XLEN'(gpio_sync_q);
      mcu_pkg::STATUS_OFFSET:   rdata_d = mcu_pkg::XLEN'(pre_load_finished_i);
      mcu_pkg::EXIT_OFFSET:     rdata_d = exit_value_q;
      default:                  rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o      = rdata_q;
  assign gpio_o       = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// ==== bus_arbiter.sv ====
/* Round-robin arbiter, one grant per cycle, combinational in the request cycle.
   Responses must arrive exactly one cycle after their grant. */
`timescale 1ns/1ps

module bus_arbiter #(
  parameter int unsigned NUM_MASTERS = 2
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  mcu_pkg::obi_req_t  [NUM_MASTERS-1:0]      master_req_i,
  output mcu_pkg::obi_resp_t [NUM_MASTERS-1:0]      master_resp_o,
  output mcu_pkg::obi_req_t                         bus_req_o,
  input  logic                                      bus_rvalid_i,
  input  logic [mcu_pkg::XLEN-1:0]                  bus_rdata_i
);

  localparam int unsigned IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] rsp_idx_q;
  logic [IDX_W-1:0] gnt_idx;
  logic             gnt_valid;

  // search starts just after the last winner
  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = last_q;
    for (int unsigned k = 1; k <= NUM_MASTERS; k++) begin
      cand = (last_q + k) % NUM_MASTERS;
      if (!gnt_valid && master_req_i[cand].req) begin
        gnt_valid = 1'b1;
        gnt_idx   = IDX_W'(cand);
      end
    end
  end

  always_comb begin
    bus_req_o     = master_req_i[gnt_idx];
    bus_req_o.req = gnt_valid;
  end

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      master_resp_o[i].gnt    = gnt_valid && (gnt_idx == IDX_W'(i));
      master_resp_o[i].rvalid = bus_rvalid_i && (rsp_idx_q == IDX_W'(i));
      master_resp_o[i].rdata  = (rsp_idx_q == IDX_W'(i)) ? bus_rdata_i : '0;
    end
  end

  // master 0 wins the first contest after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q    <= IDX_W'(NUM_MASTERS - 1);
      rsp_idx_q <= '0;
    end else if (gnt_valid) begin
      last_q    <= gnt_idx;
      rsp_idx_q <= gnt_idx;
    end
  end

endmodule

// ==== mcu_pkg.sv ====
/* Shared bus types and address map for the mini MCU fabric.
   Word accesses only; the bus has no byte enables. */
package mcu_pkg;

  localparam int unsigned XLEN = 32;

  typedef struct packed {
    logic            req;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } obi_resp_t;

  // master 0 is the host, master 1 the pre-load engine
  localparam int unsigned NUM_MASTERS = 2;

  // address map, regions selected by bits above REGION_LSB-1
  localparam int unsigned     REGION_LSB = 16;
  localparam logic [XLEN-1:0] RAM_BASE   = 32'h0000_0000;
  localparam logic [XLEN-1:0] AO_BASE    = 32'h0001_0000;

  // always-on register offsets
  localparam logic [XLEN-1:0] GPIO_OUT_OFFSET = 32'h0000_0000;
  localparam logic [XLEN-1:0] GPIO_OE_OFFSET  = 32'h0000_0004;
  localparam logic [XLEN-1:0] GPIO_IN_OFFSET  = 32'h0000_0008;
  localparam logic [XLEN-1:0] STATUS_OFFSET   = 32'h0000_000C;
  localparam logic [XLEN-1:0] EXIT_OFFSET     = 32'h0000_0010;

  localparam int unsigned DEFAULT_RAM_WORDS     = 256;
  localparam int unsigned DEFAULT_NUM_GPIO      = 8;
  localparam int unsigned DEFAULT_PRELOAD_WORDS = 16;

  // xored with the word index for each pre-loaded word
  localparam logic [XLEN-1:0] PRELOAD_KEY = 32'h5A5A_0000;

endpackage

// ==== mini_mcu.sv ====
/* Always-on fabric with host and pre-load masters sharing one bus.
   Host requests must follow the OBI handshake; slaves never stall. */
`timescale 1ns/1ps

module mini_mcu #(
  parameter int unsigned RAM_WORDS     = mcu_pkg::DEFAULT_RAM_WORDS,
  parameter int unsigned NUM_GPIO      = mcu_pkg::DEFAULT_NUM_GPIO,
  parameter int unsigned PRELOAD_WORDS = mcu_pkg::DEFAULT_PRELOAD_WORDS
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mcu_pkg::obi_req_t         host_req_i,
  output mcu_pkg::obi_resp_t        host_resp_o,
  input  logic [NUM_GPIO-1:0]       gpio_i,
  output logic [NUM_GPIO-1:0]       gpio_o,
  output logic [NUM_GPIO-1:0]       gpio_oe_o,
  output logic                      exit_valid_o,
  output logic [mcu_pkg::XLEN-1:0]  exit_value_o
);

  // master side
  mcu_pkg::obi_req_t  [mcu_pkg::NUM_MASTERS-1:0] master_req;
  mcu_pkg::obi_resp_t [mcu_pkg::NUM_MASTERS-1:0] master_resp;
  mcu_pkg::obi_req_t                             preload_req;
  mcu_pkg::obi_resp_t                            preload_resp;
  logic                                          pre_load_finished;

  // slave side
  mcu_pkg::obi_req_t        bus_req;
  logic                     bus_rvalid;
  logic [mcu_pkg::XLEN-1:0] bus_rdata;
  mcu_pkg::obi_req_t        ram_req;
  logic [mcu_pkg::XLEN-1:0] ram_rdata;
  mcu_pkg::obi_req_t        ao_req;
  logic [mcu_pkg::XLEN-1:0] ao_rdata;

  assign master_req[0] = host_req_i;
  assign master_req[1] = preload_req;
  assign host_resp_o   = master_resp[0];
  assign preload_resp  = master_resp[1];

  pre_load_mem #(
    .PRELOAD_WORDS(PRELOAD_WORDS)
  ) i_pre_load_mem (
    .clk_i,
    .rst_n_i,
    .master_req_o       (preload_req),
    .master_resp_i      (preload_resp),
    .pre_load_finished_o(pre_load_finished)
  );

  bus_arbiter #(
    .NUM_MASTERS(mcu_pkg::NUM_MASTERS)
  ) i_bus_arbiter (
    .clk_i,
    .rst_n_i,
    .master_req_i (master_req),
    .master_resp_o(master_resp),
    .bus_req_o    (bus_req),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata)
  );

  slave_demux #(
    .RAM_WORDS(RAM_WORDS)
  ) i_slave_demux (
    .clk_i,
    .rst_n_i,
    .bus_req_i   (bus_req),
    .bus_rvalid_o(bus_rvalid),
    .bus_rdata_o (bus_rdata),
    .ram_req_o   (ram_req),
    .ram_rdata_i (ram_rdata),
    .ao_req_o    (ao_req),
    .ao_rdata_i  (ao_rdata)
  );

  ram_bank #(
    .RAM_WORDS(RAM_WORDS)
  ) i_ram_bank (
    .clk_i,
    .req_i  (ram_req),
    .rdata_o(ram_rdata)
  );

  ao_peripheral #(
    .NUM_GPIO(NUM_GPIO)
  ) i_ao_peripheral (
    .clk_i,
    .rst_n_i,
    .req_i              (ao_req),
    .rdata_o            (ao_rdata),
    .pre_load_finished_i(pre_load_finished),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .exit_valid_o,
    .exit_value_o
  );

endmodule

// ==== mini_mcu_sva.sv ====
/* OBI protocol checks bound into mini_mcu.
   Grant latency holds only while the host keeps req up until its grant. */
`timescale 1ns/1ps

module mini_mcu_sva (
  input logic                                          clk_i,
  input logic                                          rst_n_i,
  input mcu_pkg::obi_req_t                             host_req,
  input mcu_pkg::obi_resp_t                            host_resp,
  input mcu_pkg::obi_req_t  [mcu_pkg::NUM_MASTERS-1:0] master_req,
  input mcu_pkg::obi_resp_t [mcu_pkg::NUM_MASTERS-1:0] master_resp,
  input logic                                          exit_valid
);

  host_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp.gnt |=> host_resp.rvalid)
    else $error("host rvalid missing one cycle after grant");

  host_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp.rvalid |-> $past(host_resp.gnt))
    else $error("host rvalid without a grant in the previous cycle");

  // two masters, so a waiting host wins the next cycle
  host_grant_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (host_req.req && !host_resp.gnt) |=> host_resp.gnt)
    else $error("held host request not granted within 2 cycles");

  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$fell(exit_valid))
    else $error("exit valid dropped while out of reset");

  for (genvar m = 0; m < mcu_pkg::NUM_MASTERS; m++) begin : g_gnt_req
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      master_resp[m].gnt |-> master_req[m].req)
      else $error("grant without request on master %0d", m);
  end

endmodule

bind mini_mcu mini_mcu_sva i_mini_mcu_sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .host_req   (host_req_i),
  .host_resp  (host_resp_o),
  .master_req (master_req),
  .master_resp(master_resp),
  .exit_valid (exit_valid_o)
);

// ==== pre_load_mem.sv ====
/* Writes PRELOAD_KEY xor index to the first PRELOAD_WORDS RAM words after reset.
   Runs once per reset; duration depends on competing host traffic. */
`timescale 1ns/1ps

module pre_load_mem #(
  parameter int unsigned PRELOAD_WORDS = 16
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  output mcu_pkg::obi_req_t  master_req_o,
  input  mcu_pkg::obi_resp_t master_resp_i,
  output logic               pre_load_finished_o
);

  localparam int unsigned CW = $clog2(PRELOAD_WORDS + 1);

  logic          started_q;
  logic          finished_q;
  logic [CW-1:0] issue_cnt_q;
  logic [1:0]    outst_q;
  logic          all_issued;

  assign all_issued = (issue_cnt_q == CW'(PRELOAD_WORDS));

  always_comb begin
    master_req_o.req   = started_q && !all_issued;
    master_req_o.we    = 1'b1;
    master_req_o.addr  = mcu_pkg::RAM_BASE + (mcu_pkg::XLEN'(issue_cnt_q) << 2);
    master_req_o.wdata = mcu_pkg::PRELOAD_KEY ^ mcu_pkg::XLEN'(issue_cnt_q);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      started_q   <= 1'b0;
      finished_q  <= 1'b0;
      issue_cnt_q <= '0;
      outst_q     <= '0;
    end else begin
      started_q <= 1'b1;
      if (master_resp_i.gnt) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
      case ({master_resp_i.gnt, master_resp_i.rvalid})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: ;
      endcase
      // last response back, nothing left to issue
      if (all_issued && master_resp_i.rvalid && outst_q == 2'd1) begin
        finished_q <= 1'b1;
      end
    end
  end

  assign pre_load_finished_o = finished_q;

endmodule

// ==== ram_bank.sv ====
/* Single-port word RAM, contents undefined after power-up.
   Read data holds until the next read. */
`timescale 1ns/1ps

module ram_bank #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                      clk_i,
  input  mcu_pkg::obi_req_t         req_i,
  output logic [mcu_pkg::XLEN-1:0]  rdata_o
);

  localparam int unsigned AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [mcu_pkg::XLEN-1:0] mem [RAM_WORDS];
  logic [mcu_pkg::XLEN-1:0] rdata_q;
  logic [AW-1:0]            word_idx;

  // byte address to word index
  assign word_idx = req_i.addr[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem[word_idx] <= req_i.wdata;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mini MCU testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_mini_mcu

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -qx "sim passed" "$LOG_FILE"; then
  echo "result: PASS"
  exit 0
else
  echo "result: FAIL"
  exit 1
fi

// ==== slave_demux.sv ====
/* Region decoder for RAM and always-on peripherals.
   Slaves see region offsets; anything else reads 0 but still answers. */
`timescale 1ns/1ps

module slave_demux #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mcu_pkg::obi_req_t         bus_req_i,
  output logic                      bus_rvalid_o,
  output logic [mcu_pkg::XLEN-1:0]  bus_rdata_o,
  output mcu_pkg::obi_req_t         ram_req_o,
  input  logic [mcu_pkg::XLEN-1:0]  ram_rdata_i,
  output mcu_pkg::obi_req_t         ao_req_o,
  input  logic [mcu_pkg::XLEN-1:0]  ao_rdata_i
);

  localparam int unsigned LSB = mcu_pkg::REGION_LSB;

  logic [mcu_pkg::XLEN-1:0] offset;
  logic                     ram_hit;
  logic                     ao_hit;
  logic                     ram_sel_q;
  logic                     ao_sel_q;
  logic                     valid_q;

  assign offset  = {{(mcu_pkg::XLEN - LSB){1'b0}}, bus_req_i.addr[LSB-1:0]};
  // ram region is only as large as the bank
  assign ram_hit = ((bus_req_i.addr >> LSB) == (mcu_pkg::RAM_BASE >> LSB)) &&
                   (offset[mcu_pkg::XLEN-1:2] < RAM_WORDS);
  assign ao_hit  = (bus_req_i.addr >> LSB) == (mcu_pkg::AO_BASE >> LSB);

  always_comb begin
    ram_req_o      = bus_req_i;
    ram_req_o.addr = offset;
    ram_req_o.req  = bus_req_i.req && ram_hit;
    ao_req_o       = bus_req_i;
    ao_req_o.addr  = offset;
    ao_req_o.req   = bus_req_i.req && ao_hit;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      ram_sel_q <= 1'b0;
      ao_sel_q  <= 1'b0;
    end else begin
      valid_q   <= bus_req_i.req;
      ram_sel_q <= bus_req_i.req && ram_hit;
      ao_sel_q  <= bus_req_i.req && ao_hit;
    end
  end

  assign bus_rvalid_o = valid_q;
  assign bus_rdata_o  = ram_sel_q ? ram_rdata_i :
                        ao_sel_q  ? ao_rdata_i  : '0;

endmodule

// ==== tb_mini_mcu.sv ====
/* Testbench for the mini MCU fabric through the host port.
   Inputs change on the falling edge, outputs are sampled 1 ns after it. */
`timescale 1ns/1ps

module tb_mini_mcu;

  localparam int unsigned NUM_GPIO      = mcu_pkg::DEFAULT_NUM_GPIO;
  localparam int unsigned PRELOAD_WORDS = mcu_pkg::DEFAULT_PRELOAD_WORDS;
  // roughly 80 host accesses of 2 to 4 cycles each, with wide margin
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic                     clk_i;
  logic                     rst_n_i;
  mcu_pkg::obi_req_t        host_req_i;
  mcu_pkg::obi_resp_t       host_resp_o;
  logic [NUM_GPIO-1:0]      gpio_i;
  logic [NUM_GPIO-1:0]      gpio_o;
  logic [NUM_GPIO-1:0]      gpio_oe_o;
  logic                     exit_valid_o;
  logic [mcu_pkg::XLEN-1:0] exit_value_o;

  logic [31:0] rng_state   = 32'd18858;
  int          cycle_count = 0;
  int          err_count   = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          test_mark   = 0;

  mini_mcu i_mini_mcu (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // hold the driven request until gnt, then step into the response cycle
  task automatic wait_grant();
    #1;
    while (!host_resp_o.gnt) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  // rvalid and rdata one cycle after the grant
  task automatic take_response(input logic [31:0] addr, output logic [31:0] rdata);
    #1;
    check_count++;
    assert (host_resp_o.rvalid) else begin
      err_count++;
      $display("host response missing one cycle after grant at address 0x%08h", addr);
    end
    rdata = host_resp_o.rdata;
  endtask

  // one OBI transfer: hold the request until gnt, capture the response a cycle later
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk_i);
    host_req_i.req   = 1'b1;
    host_req_i.we    = we;
    host_req_i.addr  = addr;
    host_req_i.wdata = wdata;
    wait_grant();
    host_req_i = '0;
    take_response(addr, rdata);
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  // second request follows the first grant directly, a requesting pre-load engine wins between
  task automatic write_back_to_back(input logic [31:0] addr0, input logic [31:0] data0,
                                    input logic [31:0] addr1, input logic [31:0] data1);
    logic [31:0] unused;
    @(negedge clk_i);
    host_req_i.req   = 1'b1;
    host_req_i.we    = 1'b1;
    host_req_i.addr  = addr0;
    host_req_i.wdata = data0;
    wait_grant();
    host_req_i.addr  = addr1;
    host_req_i.wdata = data1;
    take_response(addr0, unused);
    wait_grant();
    host_req_i = '0;
    take_response(addr1, unused);
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count == test_mark) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, err_count - test_mark);
    end
    test_mark = err_count;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] host_data [16];
    logic [31:0] out_val;
    logic [31:0] oe_val;
    logic [31:0] in_val;
    logic [31:0] exit_val;
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    host_req_i = '0;
    gpio_i     = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;

    check_eq("gpio_o", 32'(gpio_o), 32'h0);
    check_eq("gpio_oe_o", 32'(gpio_oe_o), 32'h0);
    check_eq("exit_valid_o", 32'(exit_valid_o), 32'h0);
    check_eq("exit_value_o", exit_value_o, 32'h0);
    check_eq("host_resp_o.gnt", 32'(host_resp_o.gnt), 32'h0);
    check_eq("host_resp_o.rvalid", 32'(host_resp_o.rvalid), 32'h0);
    end_test("reset values");

    // pre-load engine is competing for the bus here
    assert (!i_mini_mcu.pre_load_finished) else begin
      err_count++;
      $display("pre-load finished before the contention test started");
    end
    for (int i = 0; i < 16; i++) begin
      rng_state    = xorshift32(rng_state);
      host_data[i] = rng_state;
    end
    for (int i = 0; i < 16; i += 2) begin
      write_back_to_back(mcu_pkg::RAM_BASE + 32'((64 + i) * 4), host_data[i],
                         mcu_pkg::RAM_BASE + 32'((65 + i) * 4), host_data[i + 1]);
    end
    for (int i = 0; i < 16; i++) begin
      host_read(mcu_pkg::RAM_BASE + 32'((64 + i) * 4), rd);
      check_eq($sformatf("host_resp_o.rdata ram word %0d", 64 + i), rd, host_data[i]);
    end
    end_test("host traffic during pre-load");

    rd = 32'h0;
    while (rd[0] !== 1'b1) begin
      host_read(mcu_pkg::AO_BASE + mcu_pkg::STATUS_OFFSET, rd);
    end
    for (int i = 0; i < PRELOAD_WORDS; i++) begin
      host_read(mcu_pkg::RAM_BASE + 32'(i * 4), rd);
      check_eq($sformatf("host_resp_o.rdata ram word %0d", i), rd,
               mcu_pkg::PRELOAD_KEY ^ 32'(i));
    end
    end_test("pre-load contents");

    rng_state = xorshift32(rng_state);
    out_val   = rng_state;
    rng_state = xorshift32(rng_state);
    oe_val    = rng_state;
    host_write(mcu_pkg::AO_BASE + mcu_pkg::GPIO_OUT_OFFSET, out_val);
    host_write(mcu_pkg::AO_BASE + mcu_pkg::GPIO_OE_OFFSET, oe_val);
    check_eq("gpio_o", 32'(gpio_o), 32'(out_val[NUM_GPIO-1:0]));
    check_eq("gpio_oe_o", 32'(gpio_oe_o), 32'(oe_val[NUM_GPIO-1:0]));
    host_read(mcu_pkg::AO_BASE + mcu_pkg::GPIO_OUT_OFFSET, rd);
    check_eq("host_resp_o.rdata gpio_out", rd, 32'(out_val[NUM_GPIO-1:0]));
    host_read(mcu_pkg::AO_BASE + mcu_pkg::GPIO_OE_OFFSET, rd);
    check_eq("host_resp_o.rdata gpio_oe", rd, 32'(oe_val[NUM_GPIO-1:0]));
    end_test("gpio output and enable");

    rng_state = xorshift32(rng_state);
    in_val    = 32'(rng_state[NUM_GPIO-1:0]);
    @(negedge clk_i);
    gpio_i = in_val[NUM_GPIO-1:0];
    // two synchronizer stages plus one spare cycle
    repeat (3) @(negedge clk_i);
    host_read(mcu_pkg::AO_BASE + mcu_pkg::GPIO_IN_OFFSET, rd);
    check_eq("host_resp_o.rdata gpio_in", rd, in_val);
    host_read(mcu_pkg::AO_BASE + 32'h100, rd);
    check_eq("host_resp_o.rdata unmapped", rd, 32'h0);
    end_test("gpio input and unmapped read");

    rng_state = xorshift32(rng_state);
    exit_val  = rng_state;
    host_write(mcu_pkg::AO_BASE + mcu_pkg::EXIT_OFFSET, exit_val);
    check_eq("exit_valid_o", 32'(exit_valid_o), 32'h1);
    check_eq("exit_value_o", exit_value_o, exit_val);
    repeat (4) @(negedge clk_i);
    #1;
    check_eq("exit_valid_o", 32'(exit_valid_o), 32'h1);
    check_eq("exit_value_o", exit_value_o, exit_val);
    end_test("exit register");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
mcu_pkg.sv
bus_arbiter.sv
slave_demux.sv
ram_bank.sv
ao_peripheral.sv
pre_load_mem.sv
mini_mcu.sv
mini_mcu_sva.sv
tb_mini_mcu.sv
